//--- mwae_pkg.sv
// Shared widths, request and configuration types for the memory test engine.
// The bus carries one 32-bit word per transaction and addresses are physical.
package mwae_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int CNT_W      = 8;
  // Strides are given in cache lines of 64 bytes
  localparam int LINE_SHIFT = 6;

  localparam logic [2:0] ALG_1A = 3'd1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  // Locked test setup with the strides already scaled to bytes
  typedef struct packed {
    addr_t            start_addr;
    addr_t            real_incr;
    addr_t            real_set_offset;
    data_t            pattern;
    logic             pattern_incr;
    logic [CNT_W-1:0] txn_per_set;
    logic [CNT_W-1:0] num_sets;
    logic [CNT_W-1:0] num_loops;
  } test_cfg_t;

  typedef enum logic [2:0] {
    FSM_IDLE,
    FSM_LOCK,
    FSM_DECODE,
    FSM_RUN,
    FSM_DRAIN,
    FSM_WAIT_CLEAR
  } fsm_state_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_WRITE,
    SEQ_WR_WAIT,
    SEQ_READ,
    SEQ_RD_WAIT,
    SEQ_HOLD
  } seq_state_t;

endpackage

//--- expect_if.sv
// Expected read values from the sequencer to the compare block.
// One expectation transfers per accepted read request.
`timescale 1ns/1ns

interface expect_if
  import mwae_pkg::*;
();

  logic             valid;
  logic             ready;
  addr_t            addr;
  data_t            pattern;
  logic [CNT_W-1:0] loop;
  logic [CNT_W-1:0] set;

  modport seq (output valid, addr, pattern, loop, set, input ready);
  modport cmp (input valid, addr, pattern, loop, set, output ready);

endinterface

//--- mwae_cfg_decode.sv
// Locks the test setup on a lock strobe and derives strides and counts one cycle later.
// A set count of zero runs one set, as an increment count of zero runs one transaction.
// The locked values are undefined until the first lock after reset.
`timescale 1ns/1ns

module mwae_cfg_decode
  import mwae_pkg::*;
(
  input  logic             i_rtl_clk,
  input  logic             i_reset_n,
  input  logic             i_lock,
  input  logic [2:0]       i_algorithm,
  input  addr_t            i_start_addr,
  input  addr_t            i_addr_incr,
  input  addr_t            i_set_offset,
  input  data_t            i_pattern,
  input  logic             i_pattern_param,
  input  logic [CNT_W-1:0] i_num_incr,
  input  logic [CNT_W-1:0] i_num_sets,
  input  logic [CNT_W-1:0] i_num_loops,
  output test_cfg_t        o_cfg,
  output logic             o_cfg_illegal
);

  addr_t            start_q;
  addr_t            incr_q;
  addr_t            set_off_q;
  data_t            pattern_q;
  logic             pattern_incr_q;
  logic [CNT_W-1:0] num_incr_q;
  logic [CNT_W-1:0] num_sets_q;
  logic [CNT_W-1:0] num_loops_q;
  addr_t            real_incr_q;
  addr_t            real_set_off_q;
  logic [CNT_W-1:0] txn_per_set_q;
  logic [CNT_W-1:0] sets_q;
  logic             illegal_q;

  always_ff @(posedge i_rtl_clk)
  begin
    if (i_lock)
    begin
      start_q        <= i_start_addr;
      incr_q         <= i_addr_incr;
      set_off_q      <= i_set_offset;
      pattern_q      <= i_pattern;
      pattern_incr_q <= i_pattern_param;
      num_incr_q     <= i_num_incr;
      num_sets_q     <= i_num_sets;
      num_loops_q    <= i_num_loops;
    end
  end

  // Only algorithm 1a is built, and a zero loop count would never end
  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
      illegal_q <= 1'b0;
    else if (i_lock)
      illegal_q <= (i_algorithm != ALG_1A) || (i_num_loops == '0);
  end

  always_ff @(posedge i_rtl_clk)
  begin
    real_incr_q    <= incr_q << LINE_SHIFT;
    real_set_off_q <= set_off_q << LINE_SHIFT;
    txn_per_set_q  <= (num_incr_q == '0) ? CNT_W'(1) : num_incr_q;
    sets_q         <= (num_sets_q == '0) ? CNT_W'(1) : num_sets_q;
  end

  always_comb
  begin
    o_cfg.start_addr      = start_q;
    o_cfg.real_incr       = real_incr_q;
    o_cfg.real_set_offset = real_set_off_q;
    o_cfg.pattern         = pattern_q;
    o_cfg.pattern_incr    = pattern_incr_q;
    o_cfg.txn_per_set     = txn_per_set_q;
    o_cfg.num_sets        = sets_q;
    o_cfg.num_loops       = num_loops_q;
  end

  assign o_cfg_illegal = illegal_q;

endmodule

//--- mwae_top_fsm.sv
// Test control. A nonzero algorithm code in idle starts a test, zero aborts it.
// After done or a config error the code must return to zero before the next start.
`timescale 1ns/1ns

module mwae_top_fsm
  import mwae_pkg::*;
(
  input  logic       i_rtl_clk,
  input  logic       i_reset_n,
  input  logic [2:0] i_algorithm,
  input  logic       i_cfg_illegal,
  input  logic       i_seq_done,
  input  logic       i_drained,
  output logic       o_lock,
  output logic       o_run,
  output logic       o_abort,
  output logic       o_busy,
  output logic       o_done,
  output logic       o_config_error
);

  fsm_state_t state_q;
  fsm_state_t state_d;
  logic       active;
  logic       go_cfg_err;

  assign active     = state_q inside {FSM_LOCK, FSM_DECODE, FSM_RUN};
  assign o_busy     = active || (state_q == FSM_DRAIN);
  assign o_lock     = (state_q == FSM_IDLE) && (i_algorithm != 3'd0);
  assign o_abort    = o_busy && (i_algorithm == 3'd0);
  assign go_cfg_err = (state_q == FSM_LOCK) && !o_abort && i_cfg_illegal;

  // The legality flag is valid from the lock state on, so an illegal test never runs
  assign o_run = active && !o_abort && !go_cfg_err;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      FSM_IDLE:
        if (o_lock)
          state_d = FSM_LOCK;
      FSM_LOCK:
        if (o_abort)
          state_d = FSM_DRAIN;
        else if (go_cfg_err)
          state_d = FSM_WAIT_CLEAR;
        else
          state_d = FSM_DECODE;
      FSM_DECODE:
        state_d = o_abort ? FSM_DRAIN : FSM_RUN;
      FSM_RUN:
        if (o_abort || i_seq_done)
          state_d = FSM_DRAIN;
      FSM_DRAIN:
        if (i_drained)
          state_d = FSM_WAIT_CLEAR;
      FSM_WAIT_CLEAR:
        if (i_algorithm == 3'd0)
          state_d = FSM_IDLE;
      default:
        state_d = FSM_IDLE;
    endcase
  end

  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
    begin
      state_q        <= FSM_IDLE;
      o_done         <= 1'b0;
      o_config_error <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Done lands in the first cycle after busy, only on the drain path
      o_done  <= (state_q == FSM_DRAIN) && i_drained;
      if (go_cfg_err)
        o_config_error <= 1'b1;
      else if ((state_q == FSM_WAIT_CLEAR) && (i_algorithm == 3'd0))
        o_config_error <= 1'b0;
    end
  end

endmodule

//--- chan_slice.sv
// One-entry valid/ready register stage for any payload type.
// The output payload is stable while valid waits for ready.
`timescale 1ns/1ns

module chan_slice #(
  parameter type payload_t = logic
)
(
  input  logic     i_rtl_clk,
  input  logic     i_reset_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  logic     full_q;
  payload_t data_q;

  // Accept when empty or when the held entry leaves this cycle
  assign o_ready = !full_q || i_ready;
  assign o_valid = full_q;
  assign o_data  = data_q;

  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
      full_q <= 1'b0;
    else if (o_ready)
      full_q <= i_valid;
  end

  always_ff @(posedge i_rtl_clk)
  begin
    if (i_valid && o_ready)
      data_q <= i_data;
  end

endmodule

//--- alg1a_sequencer.sv
// Algorithm 1a address and pattern generator. Per loop and set it writes the set,
// waits for all write responses, reads the set back and waits for all read responses.
// Address is start + set * set offset + n * increment, pattern is base + loop (+ n).
`timescale 1ns/1ns

module alg1a_sequencer
  import mwae_pkg::*;
(
  input  logic      i_rtl_clk,
  input  logic      i_reset_n,
  input  test_cfg_t i_cfg,
  input  logic      i_run,
  input  logic      i_abort,
  input  logic      i_wr_resp_valid,
  input  logic      i_rd_resp_valid,
  output logic      o_seq_done,
  output logic      o_drained,
  expect_if.seq     expect_bus,
  output logic      o_wr_valid,
  output addr_t     o_wr_addr,
  output data_t     o_wr_data,
  input  logic      i_wr_ready,
  output logic      o_rd_valid,
  output addr_t     o_rd_addr,
  input  logic      i_rd_ready
);

  seq_state_t       state_q;
  logic [CNT_W-1:0] loop_q;
  logic [CNT_W-1:0] set_q;
  logic [CNT_W-1:0] txn_q;
  logic [CNT_W:0]   wr_out_q;
  logic [CNT_W:0]   rd_out_q;
  addr_t            set_base_q;
  addr_t            cur_addr_q;
  data_t            cur_pat;
  logic             wr_in_valid;
  logic             wr_in_ready;
  logic             rd_in_valid;
  logic             rd_in_ready;
  logic             wr_push;
  logic             rd_push;
  logic             last_txn;
  logic             last_set;
  logic             last_loop;
  wr_req_t          wr_in;
  wr_req_t          wr_out;
  rd_req_t          rd_in;
  rd_req_t          rd_out;

  assign cur_pat = i_cfg.pattern + data_t'(loop_q)
                 + (i_cfg.pattern_incr ? data_t'(txn_q) : '0);

  assign last_txn  = (txn_q == i_cfg.txn_per_set - 1'b1);
  assign last_set  = (set_q == i_cfg.num_sets - 1'b1);
  assign last_loop = (loop_q == i_cfg.num_loops - 1'b1);

  assign wr_in_valid = (state_q == SEQ_WRITE);
  assign wr_push     = wr_in_valid && wr_in_ready;

  // A read leaves only together with its expectation
  assign rd_in_valid      = (state_q == SEQ_READ) && expect_bus.ready;
  assign expect_bus.valid = (state_q == SEQ_READ) && rd_in_ready;
  assign rd_push          = rd_in_valid && rd_in_ready;

  assign expect_bus.addr    = cur_addr_q;
  assign expect_bus.pattern = cur_pat;
  assign expect_bus.loop    = loop_q;
  assign expect_bus.set     = set_q;

  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
    begin
      state_q    <= SEQ_IDLE;
      loop_q     <= '0;
      set_q      <= '0;
      txn_q      <= '0;
      o_seq_done <= 1'b0;
    end
    else
    begin
      o_seq_done <= 1'b0;
      case (state_q)
        SEQ_IDLE:
          if (i_run)
          begin
            state_q    <= SEQ_WRITE;
            loop_q     <= '0;
            set_q      <= '0;
            txn_q      <= '0;
            set_base_q <= i_cfg.start_addr;
            cur_addr_q <= i_cfg.start_addr;
          end
        SEQ_WRITE, SEQ_READ:
          if (wr_push || rd_push)
          begin
            if (last_txn)
            begin
              txn_q      <= '0;
              cur_addr_q <= set_base_q;
              state_q    <= (state_q == SEQ_WRITE) ? SEQ_WR_WAIT : SEQ_RD_WAIT;
            end
            else
            begin
              txn_q      <= txn_q + 1'b1;
              cur_addr_q <= cur_addr_q + i_cfg.real_incr;
            end
          end
        SEQ_WR_WAIT:
          if (wr_out_q == '0)
            state_q <= SEQ_READ;
        SEQ_RD_WAIT:
          if (rd_out_q == '0)
          begin
            state_q <= SEQ_WRITE;
            if (!last_set)
            begin
              set_q      <= set_q + 1'b1;
              set_base_q <= set_base_q + i_cfg.real_set_offset;
              cur_addr_q <= set_base_q + i_cfg.real_set_offset;
            end
            else
            begin
              set_q      <= '0;
              set_base_q <= i_cfg.start_addr;
              cur_addr_q <= i_cfg.start_addr;
              if (last_loop)
              begin
                state_q    <= SEQ_HOLD;
                o_seq_done <= 1'b1;
              end
              else
                loop_q <= loop_q + 1'b1;
            end
          end
        SEQ_HOLD:
          if (!i_run)
            state_q <= SEQ_IDLE;
        default:
          state_q <= SEQ_IDLE;
      endcase
      // Abort stops issuing at once and lets the outstanding traffic drain
      if (i_abort && (state_q inside {SEQ_WRITE, SEQ_WR_WAIT, SEQ_READ, SEQ_RD_WAIT}))
        state_q <= SEQ_HOLD;
    end
  end

  // Outstanding counts include requests still held in the slices
  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
    begin
      wr_out_q <= '0;
      rd_out_q <= '0;
    end
    else
    begin
      wr_out_q <= wr_out_q + {{CNT_W{1'b0}}, wr_push} - {{CNT_W{1'b0}}, i_wr_resp_valid};
      rd_out_q <= rd_out_q + {{CNT_W{1'b0}}, rd_push} - {{CNT_W{1'b0}}, i_rd_resp_valid};
    end
  end

  assign o_drained = (wr_out_q == '0) && (rd_out_q == '0);

  assign wr_in.addr = cur_addr_q;
  assign wr_in.data = cur_pat;
  assign rd_in.addr = cur_addr_q;

  chan_slice #(.payload_t(wr_req_t)) u_wr_slice (
    .i_rtl_clk (i_rtl_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (wr_in_valid),
    .o_ready   (wr_in_ready),
    .i_data    (wr_in),
    .o_valid   (o_wr_valid),
    .i_ready   (i_wr_ready),
    .o_data    (wr_out)
  );

  chan_slice #(.payload_t(rd_req_t)) u_rd_slice (
    .i_rtl_clk (i_rtl_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (rd_in_valid),
    .o_ready   (rd_in_ready),
    .i_data    (rd_in),
    .o_valid   (o_rd_valid),
    .i_ready   (i_rd_ready),
    .o_data    (rd_out)
  );

  assign o_wr_addr = wr_out.addr;
  assign o_wr_data = wr_out.data;
  assign o_rd_addr = rd_out.addr;

endmodule

//--- self_check_compare.sv
// Expectation FIFO and read data compare. EXP_DEPTH must be a power of two, 2 or more.
// Read responses return in order, one per accepted read. Only the first mismatch
// after a lock is logged, and a read with an error response is not compared.
`timescale 1ns/1ns

module self_check_compare
  import mwae_pkg::*;
#(
  parameter int EXP_DEPTH = 4
)
(
  input  logic             i_rtl_clk,
  input  logic             i_reset_n,
  input  logic             i_lock,
  input  logic             i_rd_resp_valid,
  input  data_t            i_rd_resp_data,
  input  logic             i_rd_resp_err,
  input  logic             i_wr_resp_valid,
  input  logic             i_wr_resp_err,
  expect_if.cmp            expect_bus,
  output logic             o_error_valid,
  output addr_t            o_error_addr,
  output data_t            o_error_expected,
  output data_t            o_error_observed,
  output logic [CNT_W-1:0] o_error_loop,
  output logic [CNT_W-1:0] o_error_set,
  output logic             o_slverr
);

  localparam int PTR_W = $clog2(EXP_DEPTH);

  typedef struct packed {
    addr_t            addr;
    data_t            pattern;
    logic [CNT_W-1:0] loop;
    logic [CNT_W-1:0] set;
  } exp_entry_t;

  exp_entry_t     fifo_mem [EXP_DEPTH];
  exp_entry_t     head;
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  logic           fifo_full;
  logic           fifo_empty;
  logic           push;
  logic           pop;
  logic           mismatch;

  // The extra pointer bit tells a full FIFO from an empty one
  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign fifo_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                   && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  assign expect_bus.ready = !fifo_full;
  assign push = expect_bus.valid && !fifo_full;
  assign pop  = i_rd_resp_valid && !fifo_empty;
  assign head = fifo_mem[rd_ptr_q[PTR_W-1:0]];

  assign mismatch = pop && !i_rd_resp_err && (i_rd_resp_data != head.pattern);

  always_ff @(posedge i_rtl_clk)
  begin
    if (push)
    begin
      fifo_mem[wr_ptr_q[PTR_W-1:0]].addr    <= expect_bus.addr;
      fifo_mem[wr_ptr_q[PTR_W-1:0]].pattern <= expect_bus.pattern;
      fifo_mem[wr_ptr_q[PTR_W-1:0]].loop    <= expect_bus.loop;
      fifo_mem[wr_ptr_q[PTR_W-1:0]].set     <= expect_bus.set;
    end
  end

  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge i_rtl_clk)
  begin
    if (!i_reset_n)
    begin
      o_error_valid <= 1'b0;
      o_slverr      <= 1'b0;
    end
    else if (i_lock)
    begin
      o_error_valid <= 1'b0;
      o_slverr      <= 1'b0;
    end
    else
    begin
      if (mismatch)
        o_error_valid <= 1'b1;
      if ((i_rd_resp_valid && i_rd_resp_err) || (i_wr_resp_valid && i_wr_resp_err))
        o_slverr <= 1'b1;
    end
  end

  always_ff @(posedge i_rtl_clk)
  begin
    if (mismatch && !o_error_valid)
    begin
      o_error_addr     <= head.addr;
      o_error_expected <= head.pattern;
      o_error_observed <= i_rd_resp_data;
      o_error_loop     <= head.loop;
      o_error_set      <= head.set;
    end
  end

endmodule

//--- mwae_top.sv
// Memory test engine running algorithm 1a with self-checking, one word per transaction.
// Responses must come back in order and are always accepted.
// Settings are sampled once when a nonzero algorithm code starts a test.
`timescale 1ns/1ns

module mwae_top
  import mwae_pkg::*;
#(
  parameter int EXP_DEPTH = 4
)
(
  input  logic             rtl_clk,
  input  logic             reset_n,
  input  logic [2:0]       i_algorithm,
  input  addr_t            i_start_addr,
  input  addr_t            i_addr_incr,
  input  addr_t            i_set_offset,
  input  data_t            i_pattern,
  input  logic             i_pattern_param,
  input  logic [CNT_W-1:0] i_num_incr,
  input  logic [CNT_W-1:0] i_num_sets,
  input  logic [CNT_W-1:0] i_num_loops,
  output logic             o_wr_valid,
  output addr_t            o_wr_addr,
  output data_t            o_wr_data,
  input  logic             i_wr_ready,
  input  logic             i_wr_resp_valid,
  input  logic             i_wr_resp_err,
  output logic             o_rd_valid,
  output addr_t            o_rd_addr,
  input  logic             i_rd_ready,
  input  logic             i_rd_resp_valid,
  input  data_t            i_rd_resp_data,
  input  logic             i_rd_resp_err,
  output logic             o_busy,
  output logic             o_done,
  output logic             o_config_error,
  output logic             o_error_valid,
  output addr_t            o_error_addr,
  output data_t            o_error_expected,
  output data_t            o_error_observed,
  output logic [CNT_W-1:0] o_error_loop,
  output logic [CNT_W-1:0] o_error_set,
  output logic             o_slverr
);

  test_cfg_t cfg;
  logic      cfg_illegal;
  logic      lock;
  logic      run;
  logic      abort;
  logic      seq_done;
  logic      drained;

  expect_if u_expect ();

  mwae_cfg_decode u_decode (
    .i_rtl_clk       (rtl_clk),
    .i_reset_n       (reset_n),
    .i_lock          (lock),
    .i_algorithm     (i_algorithm),
    .i_start_addr    (i_start_addr),
    .i_addr_incr     (i_addr_incr),
    .i_set_offset    (i_set_offset),
    .i_pattern       (i_pattern),
    .i_pattern_param (i_pattern_param),
    .i_num_incr      (i_num_incr),
    .i_num_sets      (i_num_sets),
    .i_num_loops     (i_num_loops),
    .o_cfg           (cfg),
    .o_cfg_illegal   (cfg_illegal)
  );

  mwae_top_fsm u_fsm (
    .i_rtl_clk      (rtl_clk),
    .i_reset_n      (reset_n),
    .i_algorithm    (i_algorithm),
    .i_cfg_illegal  (cfg_illegal),
    .i_seq_done     (seq_done),
    .i_drained      (drained),
    .o_lock         (lock),
    .o_run          (run),
    .o_abort        (abort),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_config_error (o_config_error)
  );

  alg1a_sequencer u_seq (
    .i_rtl_clk       (rtl_clk),
    .i_reset_n       (reset_n),
    .i_cfg           (cfg),
    .i_run           (run),
    .i_abort         (abort),
    .i_wr_resp_valid (i_wr_resp_valid),
    .i_rd_resp_valid (i_rd_resp_valid),
    .o_seq_done      (seq_done),
    .o_drained       (drained),
    .expect_bus      (u_expect.seq),
    .o_wr_valid      (o_wr_valid),
    .o_wr_addr       (o_wr_addr),
    .o_wr_data       (o_wr_data),
    .i_wr_ready      (i_wr_ready),
    .o_rd_valid      (o_rd_valid),
    .o_rd_addr       (o_rd_addr),
    .i_rd_ready      (i_rd_ready)
  );

  self_check_compare #(.EXP_DEPTH(EXP_DEPTH)) u_compare (
    .i_rtl_clk        (rtl_clk),
    .i_reset_n        (reset_n),
    .i_lock           (lock),
    .i_rd_resp_valid  (i_rd_resp_valid),
    .i_rd_resp_data   (i_rd_resp_data),
    .i_rd_resp_err    (i_rd_resp_err),
    .i_wr_resp_valid  (i_wr_resp_valid),
    .i_wr_resp_err    (i_wr_resp_err),
    .expect_bus       (u_expect.cmp),
    .o_error_valid    (o_error_valid),
    .o_error_addr     (o_error_addr),
    .o_error_expected (o_error_expected),
    .o_error_observed (o_error_observed),
    .o_error_loop     (o_error_loop),
    .o_error_set      (o_error_set),
    .o_slverr         (o_slverr)
  );

endmodule

//--- mwae_checker.sv
// Protocol assertions for mwae_top, attached with bind.
// The reset check starts at the second reset edge, once the outputs are defined.
`timescale 1ns/1ns

module mwae_checker
  import mwae_pkg::*;
(
  input logic  rtl_clk,
  input logic  reset_n,
  input logic  o_wr_valid,
  input addr_t o_wr_addr,
  input data_t o_wr_data,
  input logic  i_wr_ready,
  input logic  o_rd_valid,
  input addr_t o_rd_addr,
  input logic  i_rd_ready,
  input logic  o_busy,
  input logic  o_done,
  input logic  o_config_error,
  input logic  o_error_valid,
  input logic  o_slverr
);

  int unsigned fail_count = 0;
  logic        rst_seen   = 1'b0;

  // Outputs are only defined once reset has been seen at one edge
  always @(posedge rtl_clk)
  begin
    if (!reset_n)
      rst_seen <= 1'b1;
  end

  wr_hold: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    (o_wr_valid && !i_wr_ready) |=>
      (o_wr_valid && $stable(o_wr_addr) && $stable(o_wr_data)))
    else
    begin
      fail_count++;
      $error("Write request changed or dropped before ready");
    end

  rd_hold: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    (o_rd_valid && !i_rd_ready) |=> (o_rd_valid && $stable(o_rd_addr)))
    else
    begin
      fail_count++;
      $error("Read request changed or dropped before ready");
    end

  idle_quiet: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    !o_busy |-> (!o_wr_valid && !o_rd_valid))
    else
    begin
      fail_count++;
      $error("Request valid while the engine is not busy");
    end

  done_edge: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    o_done |-> (!o_busy && $past(o_busy)))
    else
    begin
      fail_count++;
      $error("Done did not coincide with busy falling");
    end

  done_pulse: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    o_done |=> !o_done)
    else
    begin
      fail_count++;
      $error("Done lasted more than one cycle");
    end

  reset_low: assert property (@(posedge rtl_clk)
    (!reset_n && rst_seen) |-> !(o_busy || o_done || o_config_error || o_wr_valid
                                 || o_rd_valid || o_error_valid || o_slverr))
    else
    begin
      fail_count++;
      $error("Control output high during reset");
    end

endmodule

bind mwae_top mwae_checker u_checker (.*);

//--- tb_mwae.sv
// Testbench for mwae_top. A random-latency in-order memory model answers requests.
// The bound checker holds the protocol checks. Stream and result checks are made here.
`timescale 1ns/1ns

module tb_mwae;
  import mwae_pkg::*;

  localparam int TOTAL_TXN   = 94;
  localparam int WORST_STALL = 16;
  localparam int CYCLE_LIMIT = 2 * TOTAL_TXN * WORST_STALL + 2000;
  localparam data_t CORRUPT_MASK = 32'h0001_0000;

  logic             rtl_clk;
  logic             reset_n;
  logic [2:0]       i_algorithm;
  addr_t            i_start_addr;
  addr_t            i_addr_incr;
  addr_t            i_set_offset;
  data_t            i_pattern;
  logic             i_pattern_param;
  logic [CNT_W-1:0] i_num_incr;
  logic [CNT_W-1:0] i_num_sets;
  logic [CNT_W-1:0] i_num_loops;
  logic             o_wr_valid;
  addr_t            o_wr_addr;
  data_t            o_wr_data;
  logic             i_wr_ready;
  logic             i_wr_resp_valid;
  logic             i_wr_resp_err;
  logic             o_rd_valid;
  addr_t            o_rd_addr;
  logic             i_rd_ready;
  logic             i_rd_resp_valid;
  data_t            i_rd_resp_data;
  logic             i_rd_resp_err;
  logic             o_busy;
  logic             o_done;
  logic             o_config_error;
  logic             o_error_valid;
  addr_t            o_error_addr;
  data_t            o_error_expected;
  data_t            o_error_observed;
  logic [CNT_W-1:0] o_error_loop;
  logic [CNT_W-1:0] o_error_set;
  logic             o_slverr;

  logic [31:0]   lfsr = 32'h7fc8;
  int            cycles = 0;
  string         test_name = "reset";
  data_t         mem [addr_t];
  bit            set_addrs [addr_t];
  logic [63:0]   exp_wr_q [$];
  data_t         rd_data_q [$];
  logic          rd_err_q [$];
  addr_t         exp_addr = '0;
  data_t         exp_data = '0;
  int            exp_left = 0;
  int            wr_pending = 0;
  int            wr_count = 0;
  int            rd_count = 0;
  int            done_count = 0;
  int            corrupt_idx = -1;
  int            rd_err_idx = -1;
  bit            any_req = 0;
  bit            reading = 0;

  mwae_top #(.EXP_DEPTH(4)) i_dut (.*);

  // Galois LFSR stepped once per random bit
  function automatic logic rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out ? 32'hA300_0000 : 32'h0);
    return out;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic fail_value(input string what, input logic [63:0] expv, input logic [63:0] actv);
    $display("Fail %s %s: expected %h actual %h", test_name, what, expv, actv);
    abort_run("A checked value was wrong");
  endtask

  initial
  begin
    rtl_clk = 1'b0;
    forever #50 rtl_clk = ~rtl_clk;
  end

  wr_stream_check: assert property (@(posedge rtl_clk) disable iff (!reset_n)
    (o_wr_valid && i_wr_ready) |->
      (exp_left != 0 && o_wr_addr == exp_addr && o_wr_data == exp_data))
    else
      fail_value("write stream", {$sampled(exp_addr), $sampled(exp_data)},
                 {$sampled(o_wr_addr), $sampled(o_wr_data)});

  // Monitor and in-order memory model
  always @(posedge rtl_clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
      abort_run("Timeout: the run exceeded its cycle limit");
    if (i_dut.u_checker.fail_count != 0)
      abort_run("A protocol assertion in the checker failed");
    if (reset_n)
    begin
      if (o_done)
        done_count++;
      if (o_wr_valid || o_rd_valid)
        any_req = 1;
      if (o_wr_valid && i_wr_ready)
      begin
        if (reading)
        begin
          set_addrs.delete();
          reading = 0;
        end
        set_addrs[o_wr_addr] = 1;
        mem[o_wr_addr] = (wr_count == corrupt_idx) ? (o_wr_data ^ CORRUPT_MASK) : o_wr_data;
        wr_pending++;
        wr_count++;
        if (exp_wr_q.size() > 0)
          void'(exp_wr_q.pop_front());
        exp_left = exp_wr_q.size();
        if (exp_left != 0)
        begin
          exp_addr = exp_wr_q[0][63:32];
          exp_data = exp_wr_q[0][31:0];
        end
      end
      if (o_rd_valid && i_rd_ready)
      begin
        assert (wr_pending == 0 && set_addrs.exists(o_rd_addr))
        else
          abort_run("Read issued before its set's writes completed, or outside the set");
        reading = 1;
        rd_data_q.push_back(mem.exists(o_rd_addr) ? mem[o_rd_addr] : ~o_rd_addr);
        rd_err_q.push_back(rd_count == rd_err_idx);
        rd_count++;
      end
    end
    #2;
    i_wr_ready      = rand_bit() | rand_bit();
    i_rd_ready      = rand_bit() | rand_bit();
    i_wr_resp_valid = 1'b0;
    i_rd_resp_valid = 1'b0;
    i_rd_resp_err   = 1'b0;
    if (wr_pending > 0 && rand_bit())
    begin
      i_wr_resp_valid = 1'b1;
      wr_pending--;
    end
    if (rd_data_q.size() > 0 && rand_bit())
    begin
      i_rd_resp_valid = 1'b1;
      i_rd_resp_data  = rd_data_q.pop_front();
      i_rd_resp_err   = rd_err_q.pop_front();
    end
  end

  task automatic run_test(input string name, input addr_t start, input addr_t incr,
                          input addr_t soff, input data_t pat, input logic pinc,
                          input int ni, input int ns, input int nl,
                          input int c_idx, input int e_idx);
    int    tps;
    int    sets;
    int    k;
    addr_t c_addr;
    data_t c_data;
    int    c_loop;
    int    c_set;
    tps  = (ni == 0) ? 1 : ni;
    sets = (ns == 0) ? 1 : ns;
    k    = 0;
    exp_wr_q.delete();
    for (int l = 0; l < nl; l++)
      for (int s = 0; s < sets; s++)
        for (int n = 0; n < tps; n++)
        begin
          exp_wr_q.push_back({start + addr_t'(s) * (soff << 6) + addr_t'(n) * (incr << 6),
                              pat + data_t'(l) + (pinc ? data_t'(n) : 32'h0)});
          if (k == c_idx)
          begin
            c_addr = exp_wr_q[k][63:32];
            c_data = exp_wr_q[k][31:0];
            c_loop = l;
            c_set  = s;
          end
          k++;
        end
    exp_addr    = exp_wr_q[0][63:32];
    exp_data    = exp_wr_q[0][31:0];
    exp_left    = exp_wr_q.size();
    test_name   = name;
    wr_count    = 0;
    rd_count    = 0;
    done_count  = 0;
    corrupt_idx = c_idx;
    rd_err_idx  = e_idx;
    reading     = 0;
    set_addrs.delete();
    i_start_addr    = start;
    i_addr_incr     = incr;
    i_set_offset    = soff;
    i_pattern       = pat;
    i_pattern_param = pinc;
    i_num_incr      = CNT_W'(ni);
    i_num_sets      = CNT_W'(ns);
    i_num_loops     = CNT_W'(nl);
    i_algorithm     = ALG_1A;
    do @(posedge rtl_clk); while (!o_busy);
    // The start clears the sticky flags of the previous test
    assert (!o_slverr && !o_error_valid)
    else
      fail_value("flags at start", 0, {o_slverr, o_error_valid});
    do @(posedge rtl_clk); while (!o_done);
    #2;
    i_algorithm = 3'd0;
    repeat (2) @(posedge rtl_clk);
    #2;
    assert (exp_left == 0) else fail_value("writes left", 0, exp_left);
    assert (rd_count == nl * sets * tps) else fail_value("read count", nl * sets * tps, rd_count);
    assert (done_count == 1) else fail_value("done pulses", 1, done_count);
    assert (o_error_valid == (c_idx >= 0))
    else
      fail_value("error valid", c_idx >= 0, o_error_valid);
    assert (o_slverr == (e_idx >= 0)) else fail_value("slverr", e_idx >= 0, o_slverr);
    if (c_idx >= 0)
    begin
      assert (o_error_addr == c_addr) else fail_value("error addr", c_addr, o_error_addr);
      assert (o_error_expected == c_data)
      else
        fail_value("error expected", c_data, o_error_expected);
      assert (o_error_observed == (c_data ^ CORRUPT_MASK))
      else
        fail_value("error observed", c_data ^ CORRUPT_MASK, o_error_observed);
      assert (o_error_loop == c_loop) else fail_value("error loop", c_loop, o_error_loop);
      assert (o_error_set == c_set) else fail_value("error set", c_set, o_error_set);
    end
  endtask

  task automatic illegal_cfg_test(input string name, input logic [2:0] alg, input int nl);
    test_name   = name;
    done_count  = 0;
    any_req     = 0;
    i_num_loops = CNT_W'(nl);
    i_algorithm = alg;
    do @(posedge rtl_clk); while (!o_config_error);
    repeat (4) @(posedge rtl_clk);
    #2;
    assert (o_config_error) else fail_value("config error held", 1, o_config_error);
    assert (done_count == 0 && !any_req) else fail_value("activity", 0, {done_count, any_req});
    i_algorithm = 3'd0;
    do @(posedge rtl_clk); while (o_config_error);
    #2;
    assert (!o_busy) else fail_value("busy after clear", 0, o_busy);
  endtask

  initial
  begin
    reset_n         = 1'b0;
    i_algorithm     = 3'd0;
    i_start_addr    = '0;
    i_addr_incr     = '0;
    i_set_offset    = '0;
    i_pattern       = '0;
    i_pattern_param = 1'b0;
    i_num_incr      = '0;
    i_num_sets      = '0;
    i_num_loops     = '0;
    i_wr_ready      = 1'b0;
    i_wr_resp_valid = 1'b0;
    i_wr_resp_err   = 1'b0;
    i_rd_ready      = 1'b0;
    i_rd_resp_valid = 1'b0;
    i_rd_resp_data  = '0;
    i_rd_resp_err   = 1'b0;
    repeat (16) @(posedge rtl_clk);
    #2;
    reset_n = 1'b1;
    @(posedge rtl_clk);
    #2;
    run_test("loops_sets_incr", 32'h0000_4000, 32'd1, 32'd16, 32'h1234_0000, 1'b1, 4, 3, 2, -1, -1);
    run_test("corrupt_word", 32'h0000_1000, 32'd1, 32'd8, 32'hA5A5_0000, 1'b1, 4, 2, 2, 9, -1);
    illegal_cfg_test("zero_loops", ALG_1A, 0);
    illegal_cfg_test("algorithm_2", 3'd2, 1);
    run_test("read_resp_err", 32'h0000_8000, 32'd2, 32'd4, 32'h0F0F_0000, 1'b0, 2, 2, 1, -1, 2);
    run_test("zero_incr", 32'h0002_0000, 32'd3, 32'd2, 32'h5555_0000, 1'b0, 0, 3, 1, -1, -1);
    if (i_dut.u_checker.fail_count == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
      abort_run("A protocol assertion in the checker failed");
  end

endmodule

//--- sim.f
mwae_pkg.sv
expect_if.sv
mwae_cfg_decode.sv
mwae_top_fsm.sv
chan_slice.sv
alg1a_sequencer.sv
self_check_compare.sv
mwae_top.sv
mwae_checker.sv
tb_mwae.sv

//--- Bender.yml
package:
  name: mwae

sources:
  - mwae_pkg.sv
  - expect_if.sv
  - mwae_cfg_decode.sv
  - mwae_top_fsm.sv
  - chan_slice.sv
  - alg1a_sequencer.sv
  - self_check_compare.sv
  - mwae_top.sv
  - target: test
    files:
      - mwae_checker.sv
      - tb_mwae.sv
